//--- logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define CPU_DW    32  // Data word
`define CPU_IW    24  // Instruction word
`define CPU_AW    24  // Instruction and data address
`define CPU_NREG  16  // General registers, R0 reads as zero

// Opcode field
`define CPU_OP_MSB   23
`define CPU_OP_LSB   18

// Destination register, also the condition code of JRCC
// and the store data register of ST
`define CPU_RD_MSB   17
`define CPU_RD_LSB   14

// First source register
`define CPU_RS0_MSB  13
`define CPU_RS0_LSB  10

// Second source register of the register forms
`define CPU_RS1_MSB  9
`define CPU_RS1_LSB  6

// Short immediate, sign extended to a full word
// Overlaps rs1, so immediate forms read one register only
`define CPU_IMM_MSB  9
`define CPU_IMM_LSB  0

// Absolute JMP target, zero extended
`define CPU_TGT_MSB  13
`define CPU_TGT_LSB  0

`endif

//--- logic/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_DW-1:0]             word_t;
  typedef logic [`CPU_AW-1:0]             addr_t;
  typedef logic [`CPU_IW-1:0]             instr_t;
  typedef logic [$clog2(`CPU_NREG)-1:0]   reg_idx_t;

  // Codes missing from this list execute as NOP
  typedef enum logic [`CPU_OP_MSB-`CPU_OP_LSB:0] {
    NOP  = 6'h00,
    ADD  = 6'h01,
    ADDI = 6'h02,
    SUB  = 6'h03,
    SUBI = 6'h04,
    AND  = 6'h05,
    ANDI = 6'h06,
    OR   = 6'h07,
    ORI  = 6'h08,
    XOR  = 6'h09,
    XORI = 6'h0a,
    CMP  = 6'h0b,
    CMPI = 6'h0c,
    LD   = 6'h0d,  // rd = mem[rs0 + imm]
    ST   = 6'h0e,  // mem[rs0 + imm] = rd
    JMP  = 6'h0f,  // pc = target
    JRCC = 6'h10   // pc = pc + imm when cond holds
  } op_e;

  // Codes 14 and 15 both jump unconditionally
  typedef enum logic [`CPU_RD_MSB-`CPU_RD_LSB:0] {
    EQ = 4'd0,   // Z
    NE = 4'd1,   // !Z
    CS = 4'd2,   // C, unsigned higher or same
    CC = 4'd3,   // !C, unsigned lower
    MI = 4'd4,   // S
    PL = 4'd5,   // !S
    VS = 4'd6,   // V
    VC = 4'd7,   // !V
    HI = 4'd8,   // C && !Z
    LS = 4'd9,   // !C || Z
    GE = 4'd10,  // S == V
    LT = 4'd11,  // S != V
    GT = 4'd12,  // !Z && S == V
    LE = 4'd13,  // Z || S != V
    AL = 4'd14
  } cond_e;

  typedef struct packed {
    logic z;
    logic s;
    logic c;  // Carry out, or no borrow after SUB/CMP
    logic v;
  } flags_t;

  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs0;
    reg_idx_t rs1;        // Holds the data register for ST
    word_t    imm;
    logic     use_imm;    // Second ALU operand is imm
    logic     rf_wr;
    logic     reads_rs0;  // Source reads that matter to the hazard check
    logic     reads_rs1;
    cond_e    cond;
  } dec_t;

endpackage

//--- logic/cpu_decode.sv
`include "cpu_cfg.svh"

module cpu_decode (
  input  cpu_pkg::instr_t i_instr,
  output cpu_pkg::dec_t   o_dec
);

  localparam int IMM_W = `CPU_IMM_MSB - `CPU_IMM_LSB + 1;

  cpu_pkg::op_e        op_raw;
  logic [IMM_W-1:0]    imm_raw;
  cpu_pkg::word_t      imm_sext;
  cpu_pkg::word_t      tgt_zext;
  cpu_pkg::reg_idx_t   rd_field;

  assign op_raw   = cpu_pkg::op_e'(i_instr[`CPU_OP_MSB:`CPU_OP_LSB]);
  assign imm_raw  = i_instr[`CPU_IMM_MSB:`CPU_IMM_LSB];
  assign imm_sext = {{(`CPU_DW-IMM_W){imm_raw[IMM_W-1]}}, imm_raw};
  assign tgt_zext = cpu_pkg::word_t'(i_instr[`CPU_TGT_MSB:`CPU_TGT_LSB]);
  assign rd_field = i_instr[`CPU_RD_MSB:`CPU_RD_LSB];

  always_comb begin
    // Defaults describe a NOP
    o_dec.op        = cpu_pkg::NOP;
    o_dec.rd        = rd_field;
    o_dec.rs0       = i_instr[`CPU_RS0_MSB:`CPU_RS0_LSB];
    o_dec.rs1       = i_instr[`CPU_RS1_MSB:`CPU_RS1_LSB];
    o_dec.imm       = imm_sext;
    o_dec.use_imm   = 1'b0;
    o_dec.rf_wr     = 1'b0;
    o_dec.reads_rs0 = 1'b0;
    o_dec.reads_rs1 = 1'b0;
    o_dec.cond      = cpu_pkg::cond_e'(rd_field);  // Only meaningful for JRCC

    case (op_raw)
      cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR: begin
        o_dec.op        = op_raw;
        o_dec.rf_wr     = 1'b1;
        o_dec.reads_rs0 = 1'b1;
        o_dec.reads_rs1 = 1'b1;
      end
      cpu_pkg::ADDI, cpu_pkg::SUBI, cpu_pkg::ANDI, cpu_pkg::ORI, cpu_pkg::XORI: begin
        o_dec.op        = op_raw;
        o_dec.rf_wr     = 1'b1;
        o_dec.reads_rs0 = 1'b1;
        o_dec.use_imm   = 1'b1;
      end
      cpu_pkg::CMP: begin
        o_dec.op        = op_raw;  // Flags only
        o_dec.reads_rs0 = 1'b1;
        o_dec.reads_rs1 = 1'b1;
      end
      cpu_pkg::CMPI: begin
        o_dec.op        = op_raw;
        o_dec.reads_rs0 = 1'b1;
        o_dec.use_imm   = 1'b1;
      end
      cpu_pkg::LD: begin
        o_dec.op        = op_raw;
        o_dec.rf_wr     = 1'b1;
        o_dec.reads_rs0 = 1'b1;
        o_dec.use_imm   = 1'b1;
      end
      cpu_pkg::ST: begin
        // Store data comes out of read port 1, so steer rd onto rs1
        o_dec.op        = op_raw;
        o_dec.rs1       = rd_field;
        o_dec.reads_rs0 = 1'b1;
        o_dec.reads_rs1 = 1'b1;
        o_dec.use_imm   = 1'b1;
      end
      cpu_pkg::JMP: begin
        o_dec.op      = op_raw;
        o_dec.imm     = tgt_zext;  // Absolute target
        o_dec.use_imm = 1'b1;
      end
      cpu_pkg::JRCC: begin
        o_dec.op      = op_raw;    // Signed offset from the jump itself
        o_dec.use_imm = 1'b1;
      end
      default: ;                   // Unknown codes stay NOP
    endcase
  end

endmodule

//--- logic/cpu_regfile.sv
`include "cpu_cfg.svh"

module cpu_regfile (
  input  logic              i_clk,
  input  logic              i_rstb,
  input  cpu_pkg::reg_idx_t i_raddr_0,
  input  cpu_pkg::reg_idx_t i_raddr_1,
  output cpu_pkg::word_t    o_rdata_0,
  output cpu_pkg::word_t    o_rdata_1,
  input  logic              i_we,
  input  cpu_pkg::reg_idx_t i_waddr,
  input  cpu_pkg::word_t    i_wdata
);

  cpu_pkg::word_t regs [`CPU_NREG];

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      for (int i = 0; i < `CPU_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin  // R0 is never written
      regs[i_waddr] <= i_wdata;
    end
  end

  // Combinational reads, same cycle as decode
  assign o_rdata_0 = (i_raddr_0 == '0) ? '0 : regs[i_raddr_0];
  assign o_rdata_1 = (i_raddr_1 == '0) ? '0 : regs[i_raddr_1];

endmodule

//--- logic/cpu_alu.sv
module cpu_alu (
  input  cpu_pkg::op_e    i_op,
  input  cpu_pkg::word_t  i_a,
  input  cpu_pkg::word_t  i_b,
  output cpu_pkg::word_t  o_result,
  output cpu_pkg::flags_t o_flags
);

  localparam int DW = $bits(cpu_pkg::word_t);

  logic [DW:0]    sum;   // Carry in the top bit
  logic [DW:0]    diff;  // Top bit set when there is no borrow
  cpu_pkg::word_t result;
  logic           carry;
  logic           ovf;

  assign sum  = {1'b0, i_a} + {1'b0, i_b};
  assign diff = {1'b0, i_a} + {1'b0, ~i_b} + 1'b1;

  always_comb begin
    result = '0;
    carry  = 1'b0;
    ovf    = 1'b0;
    case (i_op)
      cpu_pkg::ADD, cpu_pkg::ADDI: begin
        result = sum[DW-1:0];
        carry  = sum[DW];
        ovf    = (i_a[DW-1] == i_b[DW-1]) && (sum[DW-1] != i_a[DW-1]);
      end
      cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP, cpu_pkg::CMPI: begin
        result = diff[DW-1:0];
        carry  = diff[DW];
        ovf    = (i_a[DW-1] != i_b[DW-1]) && (diff[DW-1] != i_a[DW-1]);
      end
      // Logical ops clear both C and V
      cpu_pkg::AND, cpu_pkg::ANDI: result = i_a & i_b;
      cpu_pkg::OR,  cpu_pkg::ORI:  result = i_a | i_b;
      cpu_pkg::XOR, cpu_pkg::XORI: result = i_a ^ i_b;
      default: result = '0;  // Not an ALU op, flags unused by the core
    endcase
  end

  assign o_result  = result;
  assign o_flags.z = (result == '0);
  assign o_flags.s = result[DW-1];
  assign o_flags.c = carry;
  assign o_flags.v = ovf;

endmodule

//--- logic/cpu_pc_unit.sv
module cpu_pc_unit (
  input  logic            i_clk,
  input  logic            i_rstb,
  input  logic            i_stall,
  input  logic            i_ex_valid,
  input  cpu_pkg::op_e    i_ex_op,
  input  cpu_pkg::cond_e  i_ex_cond,
  input  cpu_pkg::addr_t  i_ex_pc,
  input  cpu_pkg::word_t  i_ex_imm,
  input  cpu_pkg::flags_t i_flags,
  output logic            o_jump_taken,
  output cpu_pkg::addr_t  o_iaddr,
  output cpu_pkg::addr_t  o_pc
);

  cpu_pkg::addr_t pc_q;    // Address of the word now in decode
  cpu_pkg::addr_t pc_nxt;
  logic           cond_true;

  always_comb begin
    case (i_ex_cond)
      cpu_pkg::EQ: cond_true = i_flags.z;
      cpu_pkg::NE: cond_true = !i_flags.z;
      cpu_pkg::CS: cond_true = i_flags.c;
      cpu_pkg::CC: cond_true = !i_flags.c;
      cpu_pkg::MI: cond_true = i_flags.s;
      cpu_pkg::PL: cond_true = !i_flags.s;
      cpu_pkg::VS: cond_true = i_flags.v;
      cpu_pkg::VC: cond_true = !i_flags.v;
      cpu_pkg::HI: cond_true = i_flags.c && !i_flags.z;
      cpu_pkg::LS: cond_true = !i_flags.c || i_flags.z;
      cpu_pkg::GE: cond_true = (i_flags.s == i_flags.v);
      cpu_pkg::LT: cond_true = (i_flags.s != i_flags.v);
      cpu_pkg::GT: cond_true = !i_flags.z && (i_flags.s == i_flags.v);
      cpu_pkg::LE: cond_true = i_flags.z || (i_flags.s != i_flags.v);
      default:     cond_true = 1'b1;  // Always
    endcase
  end

  assign o_jump_taken = i_ex_valid &&
                        ((i_ex_op == cpu_pkg::JMP) || (i_ex_op == cpu_pkg::JRCC && cond_true));

  // A taken jump wins over a stall, decode gets squashed anyway
  always_comb begin
    if (o_jump_taken && i_ex_op == cpu_pkg::JMP) pc_nxt = cpu_pkg::addr_t'(i_ex_imm);
    else if (o_jump_taken)                       pc_nxt = i_ex_pc + cpu_pkg::addr_t'(i_ex_imm);
    else if (i_stall)                            pc_nxt = pc_q;  // Refetch the held word
    else                                         pc_nxt = pc_q + 1'b1;
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) pc_q <= '0;
    else         pc_q <= pc_nxt;
  end

  assign o_iaddr = pc_nxt;
  assign o_pc    = pc_q;

endmodule

//--- logic/cpu_top.sv
module cpu_top (
  input  logic            i_clk,
  input  logic            i_rstb,
  input  cpu_pkg::instr_t i_instr,
  input  cpu_pkg::word_t  i_din,
  output cpu_pkg::addr_t  o_iaddr,
  output cpu_pkg::addr_t  o_daddr,
  output cpu_pkg::word_t  o_dout,
  output logic            o_ram_rd,
  output logic            o_ram_wr
);

  localparam int DW = $bits(cpu_pkg::word_t);

  // Decode stage
  cpu_pkg::dec_t   dec;
  cpu_pkg::addr_t  dec_pc;
  logic            dec_valid_q;   // Low until the first fetch returns
  cpu_pkg::word_t  rdata_0;
  cpu_pkg::word_t  rdata_1;
  logic            hazard;
  logic            issue;         // Decode moves into execute

  // Execute stage
  logic            ex_valid_q;
  cpu_pkg::dec_t   ex_dec_q;
  cpu_pkg::word_t  ex_a_q;
  cpu_pkg::word_t  ex_b_q;
  cpu_pkg::addr_t  ex_pc_q;
  cpu_pkg::word_t  alu_result;
  cpu_pkg::flags_t alu_flags;
  cpu_pkg::flags_t flags_q;
  cpu_pkg::flags_t flags_d;
  logic            jump_taken;
  logic            rf_we;
  cpu_pkg::word_t  rf_wdata;

  cpu_decode u_decode (
    .i_instr (i_instr),
    .o_dec   (dec)
  );

  cpu_regfile u_regfile (
    .i_clk     (i_clk),
    .i_rstb    (i_rstb),
    .i_raddr_0 (dec.rs0),
    .i_raddr_1 (dec.rs1),
    .o_rdata_0 (rdata_0),
    .o_rdata_1 (rdata_1),
    .i_we      (rf_we),
    .i_waddr   (ex_dec_q.rd),
    .i_wdata   (rf_wdata)
  );

  // Read-after-write on the adjacent instruction, no bypass
  assign hazard = dec_valid_q && ex_valid_q && ex_dec_q.rf_wr && (ex_dec_q.rd != '0) &&
                  ((dec.reads_rs0 && dec.rs0 == ex_dec_q.rd) ||
                   (dec.reads_rs1 && dec.rs1 == ex_dec_q.rd));

  assign issue = dec_valid_q && !hazard && !jump_taken;  // Squash behind a taken jump

  // Memory request goes out of decode so load data lands in execute
  assign o_ram_rd = issue && (dec.op == cpu_pkg::LD);
  assign o_ram_wr = issue && (dec.op == cpu_pkg::ST);
  assign o_daddr  = cpu_pkg::addr_t'(rdata_0 + dec.imm);
  assign o_dout   = rdata_1;

  cpu_pc_unit u_pc_unit (
    .i_clk        (i_clk),
    .i_rstb       (i_rstb),
    .i_stall      (hazard || !dec_valid_q),
    .i_ex_valid   (ex_valid_q),
    .i_ex_op      (ex_dec_q.op),
    .i_ex_cond    (ex_dec_q.cond),
    .i_ex_pc      (ex_pc_q),
    .i_ex_imm     (ex_dec_q.imm),
    .i_flags      (flags_q),
    .o_jump_taken (jump_taken),
    .o_iaddr      (o_iaddr),
    .o_pc         (dec_pc)
  );

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      dec_valid_q <= 1'b0;
      ex_valid_q  <= 1'b0;
      flags_q     <= '0;
    end else begin
      dec_valid_q <= 1'b1;
      ex_valid_q  <= issue;     // Bubble on stall or squash
      flags_q     <= flags_d;
    end
  end

  // Execute payload, qualified by ex_valid_q
  always_ff @(posedge i_clk) begin
    ex_dec_q <= dec;
    ex_a_q   <= rdata_0;
    ex_b_q   <= dec.use_imm ? dec.imm : rdata_1;
    ex_pc_q  <= dec_pc;
  end

  cpu_alu u_alu (
    .i_op     (ex_dec_q.op),
    .i_a      (ex_a_q),
    .i_b      (ex_b_q),
    .o_result (alu_result),
    .o_flags  (alu_flags)
  );

  assign rf_we    = ex_valid_q && ex_dec_q.rf_wr;
  assign rf_wdata = (ex_dec_q.op == cpu_pkg::LD) ? i_din : alu_result;

  always_comb begin
    flags_d = flags_q;  // ST, jumps and NOP keep all flags
    if (ex_valid_q) begin
      case (ex_dec_q.op)
        cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI,
        cpu_pkg::AND, cpu_pkg::ANDI, cpu_pkg::OR, cpu_pkg::ORI,
        cpu_pkg::XOR, cpu_pkg::XORI, cpu_pkg::CMP, cpu_pkg::CMPI: flags_d = alu_flags;
        cpu_pkg::LD: begin
          flags_d.z = (i_din == '0);  // C and V untouched
          flags_d.s = i_din[DW-1];
        end
        default: ;
      endcase
    end
  end

endmodule

//--- dv/cpu_chk.sv
module cpu_chk (
  input logic           i_clk,
  input logic           i_rstb,
  input logic           i_ram_rd,
  input logic           i_ram_wr,
  input cpu_pkg::addr_t i_daddr,
  input cpu_pkg::word_t i_dout
);

  timeunit 1ns;
  timeprecision 1ps;

  // One data request per cycle
  a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rstb)
                                 !(i_ram_rd && i_ram_wr))
    else $error("Read and write requested in the same cycle");

  a_idle_in_reset: assert property (@(posedge i_clk)
                                    !i_rstb |-> (!i_ram_rd && !i_ram_wr))
    else $error("Memory request while reset is asserted");

  a_wr_known: assert property (@(posedge i_clk) disable iff (!i_rstb)
                               i_ram_wr |-> !$isunknown({i_daddr, i_dout}))
    else $error("Store address or data unknown");  // X here would corrupt memory

endmodule

bind cpu_top cpu_chk u_chk (
  .i_clk    (i_clk),
  .i_rstb   (i_rstb),
  .i_ram_rd (o_ram_rd),
  .i_ram_wr (o_ram_wr),
  .i_daddr  (o_daddr),
  .i_dout   (o_dout)
);

//--- dv/cpu_tb.sv
`include "cpu_cfg.svh"

module cpu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN = 200;
  localparam int HALT_PC  = PROG_LEN - 1;
  localparam int DMEM_N   = 64;
  localparam int MAX_CYC  = 3 * PROG_LEN + 50;
  localparam int T_DRIVE  = 10;
  localparam int DW       = `CPU_DW;
  localparam int IMM_W    = `CPU_IMM_MSB - `CPU_IMM_LSB + 1;

  logic            i_clk;
  logic            i_rstb;
  cpu_pkg::instr_t i_instr;
  cpu_pkg::word_t  i_din;
  cpu_pkg::addr_t  o_iaddr;
  cpu_pkg::addr_t  o_daddr;
  cpu_pkg::word_t  o_dout;
  logic            o_ram_rd;
  logic            o_ram_wr;

  cpu_pkg::instr_t imem [PROG_LEN];
  cpu_pkg::word_t  dmem [DMEM_N];      // Seen by the DUT
  cpu_pkg::word_t  ref_dmem [DMEM_N];  // Seen by the model
  cpu_pkg::addr_t  exp_addr_q [$];
  cpu_pkg::word_t  exp_data_q [$];
  cpu_pkg::addr_t  ref_halt;
  cpu_pkg::addr_t  iaddr_s;            // Requests captured mid-cycle
  cpu_pkg::addr_t  daddr_s;
  logic            rd_s;
  logic [31:0]     rng;
  int              n_stores;
  int              n_exp;
  int              cycles = 0;

  cpu_top i_dut (
    .i_clk    (i_clk),
    .i_rstb   (i_rstb),
    .i_instr  (i_instr),
    .i_din    (i_din),
    .o_iaddr  (o_iaddr),
    .o_daddr  (o_daddr),
    .o_dout   (o_dout),
    .o_ram_rd (o_ram_rd),
    .o_ram_wr (o_ram_wr)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int unsigned next_rand(input int unsigned n);
    rng = xorshift(rng);
    return rng % n;
  endfunction

  task automatic fail_run(input string why);
    $display("STATUS: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                            input cpu_pkg::addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_run("address mismatch");
    end
  endtask

  task automatic check_word(input string name, input cpu_pkg::word_t exp,
                            input cpu_pkg::word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_run("data mismatch");
    end
  endtask

  // Bits 9..0 carry either imm10 or rs1 shifted into place
  function automatic cpu_pkg::instr_t enc(input cpu_pkg::op_e op, input int rd,
                                          input int rs0, input int low);
    cpu_pkg::instr_t w;
    w = '0;
    w[`CPU_OP_MSB:`CPU_OP_LSB]   = op;
    w[`CPU_RD_MSB:`CPU_RD_LSB]   = cpu_pkg::reg_idx_t'(rd);
    w[`CPU_RS0_MSB:`CPU_RS0_LSB] = cpu_pkg::reg_idx_t'(rs0);
    w[`CPU_IMM_MSB:`CPU_IMM_LSB] = low[IMM_W-1:0];
    return w;
  endfunction

  function automatic cpu_pkg::instr_t enc_jmp(input int target);
    cpu_pkg::instr_t w;
    w = '0;
    w[`CPU_OP_MSB:`CPU_OP_LSB]   = cpu_pkg::JMP;
    w[`CPU_TGT_MSB:`CPU_TGT_LSB] = target[`CPU_TGT_MSB:0];
    return w;
  endfunction

  function automatic bit is_imm_op(input cpu_pkg::op_e op);
    return op inside {cpu_pkg::ADDI, cpu_pkg::SUBI, cpu_pkg::ANDI, cpu_pkg::ORI,
                      cpu_pkg::XORI, cpu_pkg::CMPI};
  endfunction

  function automatic cpu_pkg::instr_t alu_instr(input int rd, input int rs0);
    cpu_pkg::op_e op;
    case (next_rand(10))
      0: op = cpu_pkg::ADD;
      1: op = cpu_pkg::ADDI;
      2: op = cpu_pkg::SUB;
      3: op = cpu_pkg::SUBI;
      4: op = cpu_pkg::AND;
      5: op = cpu_pkg::ANDI;
      6: op = cpu_pkg::OR;
      7: op = cpu_pkg::ORI;
      8: op = cpu_pkg::XOR;
      default: op = cpu_pkg::XORI;
    endcase
    if (is_imm_op(op)) return enc(op, rd, rs0, next_rand(1024));
    return enc(op, rd, rs0, next_rand(16) << `CPU_RS1_LSB);
  endfunction

  // Random blocks of ALU+store, load+store, compare+branch and forward jumps
  task automatic build_program();
    int pc;
    int rd;
    int rd2;
    int kind;
    int jr_cnt;
    pc = 0;
    jr_cnt = 0;
    while (pc < PROG_LEN - 10) begin
      kind = next_rand(10);
      if (kind < 3) begin
        rd = next_rand(16);
        imem[pc] = alu_instr(rd, next_rand(16));
        pc++;
        if (next_rand(2) == 1) begin  // Dependent op right behind
          rd2 = next_rand(16);
          imem[pc] = alu_instr(rd2, rd);
          rd = rd2;
          pc++;
        end
        imem[pc] = enc(cpu_pkg::ST, rd, 0, next_rand(DMEM_N));
        pc++;
      end else if (kind < 5) begin
        rd = next_rand(16);
        imem[pc]     = enc(cpu_pkg::LD, rd, 0, next_rand(DMEM_N));
        imem[pc + 1] = enc(cpu_pkg::ST, rd, 0, next_rand(DMEM_N));
        pc += 2;
      end else if (kind < 9) begin
        if (next_rand(2) == 0)
          imem[pc] = enc(cpu_pkg::CMP, 0, next_rand(16), next_rand(16) << `CPU_RS1_LSB);
        else
          imem[pc] = enc(cpu_pkg::CMPI, 0, next_rand(16), next_rand(1024));
        imem[pc + 1] = enc(cpu_pkg::JRCC, jr_cnt % 16, 0, 2 + next_rand(4));
        imem[pc + 2] = enc(cpu_pkg::ST, next_rand(16), 0, next_rand(DMEM_N));
        jr_cnt++;
        pc += 3;
      end else begin
        imem[pc]     = enc_jmp(pc + 2 + next_rand(3));
        imem[pc + 1] = enc(cpu_pkg::ST, next_rand(16), 0, next_rand(DMEM_N));  // Never runs
        pc += 2;
      end
    end
    while (pc < HALT_PC) begin
      imem[pc] = '0;
      pc++;
    end
    imem[HALT_PC] = enc_jmp(HALT_PC);
  endtask

  function automatic bit cond_holds(input int code, input cpu_pkg::flags_t f);
    case (code)
      0:  return f.z;
      1:  return !f.z;
      2:  return f.c;
      3:  return !f.c;
      4:  return f.s;
      5:  return !f.s;
      6:  return f.v;
      7:  return !f.v;
      8:  return f.c && !f.z;
      9:  return !f.c || f.z;
      10: return f.s == f.v;
      11: return f.s != f.v;
      12: return !f.z && (f.s == f.v);
      13: return f.z || (f.s != f.v);
      default: return 1'b1;
    endcase
  endfunction

  // Instruction-level model that runs one instruction per step
  task automatic run_model();
    cpu_pkg::word_t  regs [`CPU_NREG];
    cpu_pkg::flags_t fl;
    cpu_pkg::instr_t w;
    cpu_pkg::op_e    op;
    cpu_pkg::addr_t  pc;
    cpu_pkg::addr_t  pc_next;
    cpu_pkg::addr_t  ea;
    cpu_pkg::word_t  a;
    cpu_pkg::word_t  b;
    cpu_pkg::word_t  r;
    cpu_pkg::word_t  imm;
    logic [DW:0]     wide;
    bit              alu;
    bit              done;
    int              rd;
    int              steps;
    foreach (regs[i]) regs[i] = '0;
    fl = '0;
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 4 * PROG_LEN) begin
      w   = imem[pc];
      op  = cpu_pkg::op_e'(w[`CPU_OP_MSB:`CPU_OP_LSB]);
      rd  = w[`CPU_RD_MSB:`CPU_RD_LSB];
      imm = {{(DW-IMM_W){w[`CPU_IMM_MSB]}}, w[`CPU_IMM_MSB:`CPU_IMM_LSB]};
      a   = regs[w[`CPU_RS0_MSB:`CPU_RS0_LSB]];
      b   = is_imm_op(op) ? imm : regs[w[`CPU_RS1_MSB:`CPU_RS1_LSB]];
      ea  = cpu_pkg::addr_t'(a + imm);
      pc_next = pc + 1'b1;
      alu = 1'b1;
      steps++;
      case (op)
        cpu_pkg::ADD, cpu_pkg::ADDI: begin
          wide = {1'b0, a} + {1'b0, b};
          r    = wide[DW-1:0];
          fl.c = wide[DW];
          fl.v = (a[DW-1] == b[DW-1]) && (r[DW-1] != a[DW-1]);
        end
        cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP, cpu_pkg::CMPI: begin
          wide = {1'b0, a} - {1'b0, b};
          r    = wide[DW-1:0];
          fl.c = !wide[DW];  // Set when nothing was borrowed
          fl.v = (a[DW-1] != b[DW-1]) && (r[DW-1] != a[DW-1]);
        end
        cpu_pkg::AND, cpu_pkg::ANDI: {r, fl.c, fl.v} = {a & b, 2'b00};
        cpu_pkg::OR,  cpu_pkg::ORI:  {r, fl.c, fl.v} = {a | b, 2'b00};
        cpu_pkg::XOR, cpu_pkg::XORI: {r, fl.c, fl.v} = {a ^ b, 2'b00};
        cpu_pkg::LD: r = ref_dmem[ea];
        cpu_pkg::ST: begin
          exp_addr_q.push_back(ea);
          exp_data_q.push_back(regs[rd]);
          ref_dmem[ea] = regs[rd];
          alu = 1'b0;
        end
        cpu_pkg::JMP: begin
          pc_next = cpu_pkg::addr_t'(w[`CPU_TGT_MSB:`CPU_TGT_LSB]);
          done    = (pc_next == pc);
          alu     = 1'b0;
        end
        cpu_pkg::JRCC: begin
          if (cond_holds(rd, fl)) pc_next = pc + cpu_pkg::addr_t'(imm);
          alu = 1'b0;
        end
        default: alu = 1'b0;
      endcase
      if (alu) begin
        fl.z = (r == '0);
        fl.s = r[DW-1];
        if (!(op inside {cpu_pkg::CMP, cpu_pkg::CMPI}) && rd != 0) regs[rd] = r;
      end
      if (!done) pc = pc_next;
    end
    ref_halt = pc;
    if (!done) fail_run("Reference model never reached the halt loop");
  endtask

  // Requests are captured at the falling edge where outputs are settled
  always @(negedge i_clk) begin
    iaddr_s = o_iaddr;
    rd_s    = o_ram_rd;
    daddr_s = o_daddr;
    if (o_ram_wr) begin
      if (exp_addr_q.size() == 0) begin
        $display("Store to %h seen after the last expected store", o_daddr);
        fail_run("unexpected store");
      end else begin
        check_addr($sformatf("store %0d address", n_stores), exp_addr_q.pop_front(), o_daddr);
        check_word($sformatf("store %0d data", n_stores), exp_data_q.pop_front(), o_dout);
        dmem[o_daddr] = o_dout;
        n_stores++;
      end
    end
  end

  // Synchronous memories answer one cycle after the request
  always @(posedge i_clk) begin
    #T_DRIVE;
    i_instr = (iaddr_s < PROG_LEN) ? imem[iaddr_s] : '0;
    if (rd_s) begin
      if (daddr_s >= DMEM_N) fail_run("Load address outside the data memory");
      else i_din = dmem[daddr_s];
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > MAX_CYC) fail_run("Timeout, the program never settled in its halt loop");
  end

  initial begin
    i_rstb   = 1'b0;
    i_instr  = '0;
    i_din    = '0;
    iaddr_s  = '0;
    daddr_s  = '0;
    rd_s     = 1'b0;
    n_stores = 0;
    rng      = 32'hdff5_74db;
    for (int i = 0; i < DMEM_N; i++) begin
      rng         = xorshift(rng);
      dmem[i]     = rng;
      ref_dmem[i] = rng;
    end
    build_program();
    run_model();
    n_exp = exp_addr_q.size();
    repeat (4) @(posedge i_clk);
    #T_DRIVE;
    i_rstb = 1'b1;
    while (o_iaddr != ref_halt) @(negedge i_clk);
    repeat (2) @(negedge i_clk);  // Halt loop refetches every other cycle
    check_addr("halt loop fetch", ref_halt, o_iaddr);
    repeat (4) @(negedge i_clk);
    check_word("store count", cpu_pkg::word_t'(n_exp), cpu_pkg::word_t'(n_stores));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- project.f
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_regfile.sv
logic/cpu_alu.sv
logic/cpu_pc_unit.sv
logic/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - logic

sources:
  - logic/cpu_pkg.sv
  - logic/cpu_decode.sv
  - logic/cpu_regfile.sv
  - logic/cpu_alu.sv
  - logic/cpu_pc_unit.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - dv/cpu_chk.sv
      - dv/cpu_tb.sv
